// ==== all.f ====
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_apb_regs.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_ctrl.sv
verification/uart_ctrl_tb.sv

// ==== design/uart_apb_regs.sv ====
// UART APB register block
// Decodes zero-wait-state APB transfers, holds IER/DIV/MCR and sticky overrun,
// pushes and pops the FIFOs, builds LSR and drives the registered interrupt

`timescale 1ns/1ps

module uart_apb_regs (
  input  logic                clock,
  input  logic                reset,
  input  uart_pkg::apb_req_t  apb_i,
  output uart_pkg::data_t     prdata_o,
  output logic                pready_o,
  output logic                tx_push_o,
  output uart_pkg::data_t     tx_data_o,
  input  uart_pkg::fifo_cnt_t tx_count_i,
  input  logic                tx_busy_i,
  output logic                rx_pop_o,
  input  uart_pkg::data_t     rx_data_i,
  input  uart_pkg::fifo_cnt_t rx_count_i,
  input  logic                rx_overrun_i,
  output uart_pkg::div_t      div_o,
  output logic                loop_o,
  output logic                int_o
);
  import uart_pkg::*;

  logic       access;
  logic       wr_en;
  logic       rd_en;
  logic [1:0] ier_q;
  logic       overrun_q;
  logic       tx_full;
  logic       rx_ready;
  data_t      lsr;

  // Access cycle of a transfer
  assign access   = apb_i.sel && apb_i.enable;
  assign wr_en    = access && apb_i.write;
  assign rd_en    = access && !apb_i.write;
  assign pready_o = access;

  assign tx_full  = (tx_count_i == fifo_cnt_t'(FIFO_DEPTH));
  assign rx_ready = (rx_count_i != '0);

  // Writes to a full transmit FIFO are lost
  assign tx_push_o = wr_en && (apb_i.addr == ADDR_DATA) && !tx_full;
  assign tx_data_o = apb_i.wdata;

  // Pop only when something is there
  assign rx_pop_o = rd_en && (apb_i.addr == ADDR_DATA) && rx_ready;

  // Line status
  assign lsr = {3'b000, !tx_busy_i, tx_full, tx_count_i == '0, overrun_q, rx_ready};

  // Read mux, empty receive FIFO reads as zero
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (apb_i.addr)
        ADDR_DATA: prdata_o = rx_ready ? rx_data_i : '0;
        ADDR_IER:  prdata_o = {6'b0, ier_q};
        ADDR_LSR:  prdata_o = lsr;
        ADDR_DIV:  prdata_o = div_o;
        ADDR_MCR:  prdata_o = {7'b0, loop_o};
        default:   prdata_o = '0;
      endcase
    end
  end

  // Control registers
  always_ff @(posedge clock) begin
    if (!reset) begin
      ier_q  <= '0;
      div_o  <= 8'd1;
      loop_o <= 1'b0;
    end else if (wr_en) begin
      case (apb_i.addr)
        ADDR_IER: ier_q  <= apb_i.wdata[1:0];
        // Zero divisor would stall the tick, store as 1
        ADDR_DIV: div_o  <= (apb_i.wdata == '0) ? 8'd1 : apb_i.wdata;
        ADDR_MCR: loop_o <= apb_i.wdata[0];
        default:  ;
      endcase
    end
  end

  // Sticky overrun, new overrun wins over an LSR read in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      overrun_q <= 1'b0;
    end else if (rx_overrun_i) begin
      overrun_q <= 1'b1;
    end else if (rd_en && apb_i.addr == ADDR_LSR) begin
      overrun_q <= 1'b0;
    end
  end

  // Interrupt, one cycle behind its condition
  always_ff @(posedge clock) begin
    if (!reset) begin
      int_o <= 1'b0;
    end else begin
      int_o <= (ier_q[0] && rx_ready) || (ier_q[1] && tx_count_i == '0);
    end
  end

  // Slave answers only in an access cycle that follows a setup cycle
  a_pready_access: assert property (@(posedge clock) disable iff (!reset)
    pready_o |-> $past(apb_i.sel && !apb_i.enable));

  // Every push lands in the transmit FIFO
  a_no_push_full: assert property (@(posedge clock) disable iff (!reset)
    tx_push_o |=> (tx_count_i != '0));

endmodule

// ==== design/uart_baud_gen.sv ====
// UART baud generator
// Emits a one-cycle tick every div clock cycles (16x the bit rate)

`timescale 1ns/1ps

module uart_baud_gen (
  input  logic          clock,
  input  logic          reset,
  input  uart_pkg::div_t div_i,
  output logic          tick_o
);
  import uart_pkg::*;

  div_t cnt;
  div_t div_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      cnt    <= '0;
      div_q  <= 8'd1;
      tick_o <= 1'b0;
    end else if (div_i != div_q) begin
      // New divisor, restart the period from zero
      div_q  <= div_i;
      cnt    <= div_i - 8'd1;
      tick_o <= 1'b0;
    end else if (cnt == '0) begin
      cnt    <= div_q - 8'd1;
      tick_o <= 1'b1;
    end else begin
      cnt    <= cnt - 8'd1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== design/uart_ctrl.sv ====
// UART controller top level
// APB registers, baud generator, transmitter and receiver with loopback mux

`timescale 1ns/1ps

module uart_ctrl (
  input  logic               clock,
  input  logic               reset,
  input  uart_pkg::apb_req_t apb_i,
  output uart_pkg::data_t    prdata_o,
  output logic               pready_o,
  input  logic               rx_i,
  output logic               tx_o,
  output logic               int_o
);
  import uart_pkg::*;

  logic      tx_push;
  data_t     tx_data;
  fifo_cnt_t tx_count;
  logic      tx_busy;
  logic      tx_ser;
  logic      rx_pop;
  data_t     rx_data;
  fifo_cnt_t rx_count;
  logic      rx_overrun;
  logic      rx_in;
  div_t      div;
  logic      loop;
  logic      baud_tick;

  // Loopback feeds the serializer into the receiver, line held idle
  assign rx_in = loop ? tx_ser : rx_i;
  assign tx_o  = loop ? 1'b1 : tx_ser;

  uart_apb_regs i_uart_apb_regs (
    .clock        (clock),
    .reset        (reset),
    .apb_i        (apb_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .tx_push_o    (tx_push),
    .tx_data_o    (tx_data),
    .tx_count_i   (tx_count),
    .tx_busy_i    (tx_busy),
    .rx_pop_o     (rx_pop),
    .rx_data_i    (rx_data),
    .rx_count_i   (rx_count),
    .rx_overrun_i (rx_overrun),
    .div_o        (div),
    .loop_o       (loop),
    .int_o        (int_o)
  );

  uart_baud_gen i_uart_baud_gen (
    .clock  (clock),
    .reset  (reset),
    .div_i  (div),
    .tick_o (baud_tick)
  );

  uart_tx i_uart_tx (
    .clock   (clock),
    .reset   (reset),
    .tick_i  (baud_tick),
    .push_i  (tx_push),
    .data_i  (tx_data),
    .count_o (tx_count),
    .busy_o  (tx_busy),
    .tx_o    (tx_ser)
  );

  uart_rx i_uart_rx (
    .clock     (clock),
    .reset     (reset),
    .tick_i    (baud_tick),
    .rx_i      (rx_in),
    .pop_i     (rx_pop),
    .data_o    (rx_data),
    .count_o   (rx_count),
    .overrun_o (rx_overrun)
  );

endmodule

// ==== design/uart_pkg.sv ====
// UART controller shared definitions
// Sizes, vector types, register map, FSM states and the APB request bundle

package uart_pkg;

  // FIFO sizing, count must be able to reach FIFO_DEPTH
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = 4;

  // Baud ticks per serial bit
  localparam int OVERSAMPLE = 16;

  // Vector types
  typedef logic [7:0]            data_t;
  typedef logic [7:0]            div_t;
  typedef logic [2:0]            addr_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_cnt_t;

  // Register map, word addresses
  localparam addr_t ADDR_DATA = 3'd0;
  localparam addr_t ADDR_IER  = 3'd1;
  localparam addr_t ADDR_LSR  = 3'd2;
  localparam addr_t ADDR_DIV  = 3'd3;
  localparam addr_t ADDR_MCR  = 3'd4;

  // APB request from the master
  typedef struct packed {
    logic  sel;
    logic  enable;
    logic  write;
    addr_t addr;
    data_t wdata;
  } apb_req_t;

  // Serializer states
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  // Deserializer states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

// ==== design/uart_rx.sv ====
// UART receiver
// Two-flop synchronizer, start edge detect, mid-bit sampling and 8-entry FIFO

`timescale 1ns/1ps

module uart_rx (
  input  logic                clock,
  input  logic                reset,
  input  logic                tick_i,
  input  logic                rx_i,
  input  logic                pop_i,
  output uart_pkg::data_t     data_o,
  output uart_pkg::fifo_cnt_t count_o,
  output logic                overrun_o
);
  import uart_pkg::*;

  logic [1:0]            sync_q;
  logic                  rx_prev;
  logic                  rx_s;
  rx_state_t             state;
  logic [3:0]            tick_cnt;
  logic [2:0]            bit_idx;
  data_t                 shift_q;
  logic                  frame_ok;
  logic                  push;
  logic                  pop;
  logic                  full;
  data_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-2:0] wr_ptr;
  logic [FIFO_PTR_W-2:0] rd_ptr;

  assign rx_s = sync_q[1];
  assign full = (count_o == fifo_cnt_t'(FIFO_DEPTH));

  // Input synchronizer plus edge history, idle high
  always_ff @(posedge clock) begin
    if (!reset) begin
      sync_q  <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      rx_prev <= rx_s;
    end
  end

  // Stop bit sampled high at its middle
  assign frame_ok = (state == RX_STOP) && tick_i &&
                    (tick_cnt == 4'(OVERSAMPLE - 1)) && rx_s;
  assign push = frame_ok && !full;
  assign pop  = pop_i && (count_o != '0);

  // Deserializer FSM
  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      if (state != RX_IDLE && tick_i) tick_cnt <= tick_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          tick_cnt <= '0;
          if (rx_prev && !rx_s) state <= RX_START;
        end
        RX_START: begin
          // Re-check at mid start bit, a high line means a glitch
          if (tick_i && tick_cnt == 4'(OVERSAMPLE / 2 - 1)) begin
            tick_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (tick_i && tick_cnt == 4'(OVERSAMPLE - 1)) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (tick_i && tick_cnt == 4'(OVERSAMPLE - 1)) state <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clock) begin
    if (state == RX_DATA && tick_i && tick_cnt == 4'(OVERSAMPLE - 1)) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr] <= shift_q;
  end

  // FIFO pointers, count and overrun pulse
  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count_o   <= '0;
      overrun_o <= 1'b0;
    end else begin
      overrun_o <= frame_ok && full;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count_o <= count_o + 1'b1;
      end else if (pop && !push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

  // Head of FIFO, visible ahead of the pop
  assign data_o = mem[rd_ptr];

  a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset)
    pop_i |-> (count_o != '0));

endmodule

// ==== design/uart_tx.sv ====
// UART transmitter
// 8-entry FIFO feeding an 8N1 serializer, LSB first, 16 ticks per bit

`timescale 1ns/1ps

module uart_tx (
  input  logic                clock,
  input  logic                reset,
  input  logic                tick_i,
  input  logic                push_i,
  input  uart_pkg::data_t     data_i,
  output uart_pkg::fifo_cnt_t count_o,
  output logic                busy_o,
  output logic                tx_o
);
  import uart_pkg::*;

  data_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-2:0] wr_ptr;
  logic [FIFO_PTR_W-2:0] rd_ptr;
  logic                  push;
  logic                  pop;
  tx_state_t             state;
  logic [3:0]            tick_cnt;
  logic [2:0]            bit_idx;
  logic                  bit_end;
  data_t                 shift_q;

  assign push    = push_i && (count_o != fifo_cnt_t'(FIFO_DEPTH));
  assign bit_end = tick_i && (tick_cnt == 4'(OVERSAMPLE - 1));

  // Next byte leaves at a tick when idle, or right after a stop bit
  assign pop = (count_o != '0) &&
               ((state == TX_IDLE && tick_i) || (state == TX_STOP && bit_end));

  // FIFO storage
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // FIFO pointers and occupancy
  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count_o <= count_o + 1'b1;
      end else if (pop && !push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

  // Serializer FSM
  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      if (state != TX_IDLE && tick_i) tick_cnt <= tick_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          tick_cnt <= '0;
          if (pop) state <= TX_START;
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_idx <= '0;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= TX_STOP;
          end
        end
        TX_STOP: begin
          // Back to back frames skip idle
          if (bit_end) state <= pop ? TX_START : TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Shift register, loaded on pop
  always_ff @(posedge clock) begin
    if (pop) begin
      shift_q <= mem[rd_ptr];
    end else if (state == TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign busy_o = (state != TX_IDLE);
  assign tx_o   = (state == TX_START) ? 1'b0 :
                  (state == TX_DATA)  ? shift_q[0] : 1'b1;

  a_count_max: assert property (@(posedge clock) disable iff (!reset)
    count_o <= fifo_cnt_t'(FIFO_DEPTH));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the UART controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f all.f --top-module uart_ctrl_tb -o uart_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

output=$(./obj_dir/uart_ctrl_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

// ==== verification/uart_ctrl_tb.sv ====
// UART controller testbench
// Directed APB register, transmit, receive, loopback and interrupt tests

`timescale 1ns/1ps

module uart_ctrl_tb;
  import uart_pkg::*;

  // Serial tests run at divisor 2, so 32 clocks per bit
  localparam int TB_DIV       = 2;
  localparam int BIT_CYCLES   = OVERSAMPLE * TB_DIV;
  localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
  // 3+9 sent, 2+9 received, 2 looped back, 3 in the interrupt test
  localparam int TOTAL_FRAMES = 28;
  localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CYCLES * 20 + 100000;

  logic     clock;
  logic     reset;
  apb_req_t apb;
  data_t    prdata;
  logic     pready;
  logic     serial_in;
  logic     serial_out;
  logic     irq;
  integer   seed;
  int       value_errors;
  int       other_errors;

  uart_ctrl i_uart_ctrl (
    .clock    (clock),
    .reset    (reset),
    .apb_i    (apb),
    .prdata_o (prdata),
    .pready_o (pready),
    .rx_i     (serial_in),
    .tx_o     (serial_out),
    .int_o    (irq)
  );

  always #10 clock = ~clock;

  task automatic value_mismatch(input string what, input data_t got, input data_t exp);
    value_errors++;
    $display("[FAIL] %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
  endtask

  task automatic report_problem(input string what);
    other_errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  function automatic data_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Setup cycle, then access cycle, then bus idle
  task automatic apb_write(input addr_t addr, input data_t data);
    @(negedge clock);
    apb.sel    = 1'b1;
    apb.enable = 1'b0;
    apb.write  = 1'b1;
    apb.addr   = addr;
    apb.wdata  = data;
    @(negedge clock);
    apb.enable = 1'b1;
    @(negedge clock);
    apb = '0;
  endtask

  task automatic apb_read(input addr_t addr, output data_t data);
    @(negedge clock);
    apb.sel    = 1'b1;
    apb.enable = 1'b0;
    apb.write  = 1'b0;
    apb.addr   = addr;
    @(negedge clock);
    apb.enable = 1'b1;
    // Read data is valid inside the access cycle
    #1;
    data = prdata;
    if (pready !== 1'b1) report_problem("pready stayed low in a read access cycle");
    @(negedge clock);
    apb = '0;
  endtask

  task automatic read_expect(input addr_t addr, input data_t exp, input string what);
    data_t got;
    apb_read(addr, got);
    if (got !== exp) value_mismatch(what, got, exp);
  endtask

  // 8N1 frame on the receive line, LSB first
  task automatic send_serial(input data_t data);
    data_t bits;
    bits = data;
    @(negedge clock);
    serial_in = 1'b0;
    repeat (BIT_CYCLES) @(negedge clock);
    repeat (8) begin
      serial_in = bits[0];
      bits = bits >> 1;
      repeat (BIT_CYCLES) @(negedge clock);
    end
    serial_in = 1'b1;
    repeat (BIT_CYCLES) @(negedge clock);
  endtask

  // Waits up to idle_limit clocks for a start bit, then samples mid-bit
  task automatic expect_serial(output data_t data, output bit found, input int idle_limit);
    int waited;
    waited = 0;
    data   = '0;
    found  = 1'b0;
    while (serial_out !== 1'b0 && waited < idle_limit) begin
      @(negedge clock);
      waited++;
    end
    if (serial_out === 1'b0) begin
      found = 1'b1;
      repeat (BIT_CYCLES / 2) @(negedge clock);
      if (serial_out !== 1'b0) report_problem("start bit on tx_o not low at its middle");
      repeat (8) begin
        repeat (BIT_CYCLES) @(negedge clock);
        data = {serial_out, data[7:1]};
      end
      repeat (BIT_CYCLES) @(negedge clock);
      if (serial_out !== 1'b1) report_problem("stop bit on tx_o not high at its middle");
    end
  endtask

  task automatic wait_irq(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (irq !== level && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (irq !== level) report_problem(what);
  endtask

  // Polls LSR until transmit FIFO empty and transmitter idle
  task automatic wait_tx_drain();
    data_t lsr;
    int    polls;
    polls = 0;
    apb_read(ADDR_LSR, lsr);
    while ((lsr & 8'h14) != 8'h14 && polls < FRAME_CYCLES) begin
      apb_read(ADDR_LSR, lsr);
      polls++;
    end
    if ((lsr & 8'h14) != 8'h14) report_problem("transmitter never drained");
  endtask

  task automatic reset_values();
    if (serial_out !== 1'b1) report_problem("tx_o not high after reset");
    if (irq !== 1'b0) report_problem("int_o not low after reset");
    if (pready !== 1'b0) report_problem("pready_o not low after reset");
    // Only transmit empty and idle set
    read_expect(ADDR_LSR, 8'h14, "LSR after reset");
    read_expect(ADDR_DIV, 8'h01, "DIV after reset");
    read_expect(ADDR_IER, 8'h00, "IER after reset");
    read_expect(ADDR_MCR, 8'h00, "MCR after reset");
  endtask

  task automatic register_access();
    apb_write(ADDR_DIV, 8'd3);
    // Only the implemented bits hold ones
    apb_write(ADDR_IER, 8'hff);
    apb_write(ADDR_MCR, 8'hff);
    read_expect(ADDR_IER, 8'h03, "IER readback of all ones");
    read_expect(ADDR_MCR, 8'h01, "MCR readback of all ones");
    apb_write(ADDR_IER, 8'd0);
    apb_write(ADDR_MCR, 8'd0);
    read_expect(ADDR_DIV, 8'd3, "DIV readback");
    read_expect(ADDR_IER, 8'd0, "IER readback");
    read_expect(ADDR_MCR, 8'd0, "MCR readback");
    // Zero divisor stored as 1
    apb_write(ADDR_DIV, 8'd0);
    read_expect(ADDR_DIV, 8'd1, "DIV after writing zero");
    // Unmapped words ignore writes
    apb_write(3'd6, 8'hff);
    read_expect(3'd6, 8'h00, "unmapped address 6");
    read_expect(3'd7, 8'h00, "unmapped address 7");
    apb_write(ADDR_DIV, data_t'(TB_DIV));
    read_expect(ADDR_DIV, data_t'(TB_DIV), "DIV for serial tests");
  endtask

  task automatic transmit_frames();
    data_t sent [$];
    data_t got;
    data_t status;
    bit    found;
    int    n;
    for (int i = 0; i < 3; i++) sent.push_back(rand_byte());
    fork
      foreach (sent[i]) apb_write(ADDR_DATA, sent[i]);
      for (int i = 0; i < 3; i++) begin
        expect_serial(got, found, FRAME_CYCLES);
        if (!found) begin
          report_problem("no start bit on tx_o for a written byte");
        end else if (got !== sent[i]) begin
          value_mismatch("tx_o frame", got, sent[i]);
        end
      end
    join
    // Rest of the last stop bit
    repeat (BIT_CYCLES) @(negedge clock);
    read_expect(ADDR_LSR, 8'h14, "LSR after transmit");
    // Ninth write only fits if the first byte already left the FIFO
    sent.delete();
    for (int i = 0; i < 9; i++) sent.push_back(rand_byte());
    n     = 0;
    found = 1'b1;
    fork
      begin
        foreach (sent[i]) apb_write(ADDR_DATA, sent[i]);
        // Eight entries remain whether or not the first byte had left
        apb_read(ADDR_LSR, status);
        if ((status & 8'h0c) !== 8'h08) begin
          value_mismatch("LSR full and empty bits after burst", status & 8'h0c, 8'h08);
        end
      end
      while (found && n < 9) begin
        expect_serial(got, found, FRAME_CYCLES);
        if (found) begin
          if (got !== sent[n]) value_mismatch("tx_o burst frame", got, sent[n]);
          n++;
        end
      end
    join
    if (n < 8) report_problem("fewer than 8 frames on tx_o after 9 writes");
    repeat (BIT_CYCLES) @(negedge clock);
    read_expect(ADDR_LSR, 8'h14, "LSR after burst");
  endtask

  task automatic receive_and_overrun();
    data_t sent [$];
    for (int i = 0; i < 2; i++) sent.push_back(rand_byte());
    foreach (sent[i]) send_serial(sent[i]);
    read_expect(ADDR_LSR, 8'h15, "LSR with received data");
    foreach (sent[i]) read_expect(ADDR_DATA, sent[i], "DATA receive");
    read_expect(ADDR_LSR, 8'h14, "LSR after receive FIFO drained");
    sent.delete();
    for (int i = 0; i < 9; i++) sent.push_back(rand_byte());
    // Ninth frame meets a full FIFO
    foreach (sent[i]) send_serial(sent[i]);
    read_expect(ADDR_LSR, 8'h17, "LSR with overrun");
    read_expect(ADDR_LSR, 8'h15, "LSR after overrun cleared");
    for (int i = 0; i < 8; i++) read_expect(ADDR_DATA, sent[i], "DATA after overrun");
    // Empty FIFO reads as zero
    read_expect(ADDR_DATA, 8'h00, "DATA with receive FIFO empty");
    read_expect(ADDR_LSR, 8'h14, "LSR after overrun test");
  endtask

  task automatic loopback_path();
    data_t sent [$];
    bit    done;
    bit    tx_moved;
    done     = 1'b0;
    tx_moved = 1'b0;
    apb_write(ADDR_MCR, 8'h01);
    read_expect(ADDR_MCR, 8'h01, "MCR loopback");
    for (int i = 0; i < 2; i++) sent.push_back(rand_byte());
    fork
      begin
        foreach (sent[i]) apb_write(ADDR_DATA, sent[i]);
        wait_tx_drain();
        done = 1'b1;
      end
      while (!done) begin
        @(negedge clock);
        if (serial_out !== 1'b1) tx_moved = 1'b1;
      end
    join
    if (tx_moved) report_problem("tx_o left idle during loopback");
    foreach (sent[i]) read_expect(ADDR_DATA, sent[i], "DATA loopback");
    apb_write(ADDR_MCR, 8'h00);
  endtask

  task automatic interrupt_levels();
    data_t b;
    b = rand_byte();
    apb_write(ADDR_IER, 8'h01);
    wait_irq(1'b0, 4, "int_o high with receive FIFO empty");
    send_serial(b);
    wait_irq(1'b1, 4, "int_o did not rise after a received byte");
    read_expect(ADDR_DATA, b, "DATA under receive interrupt");
    wait_irq(1'b0, 4, "int_o did not fall after the byte was read");
    // Transmit-empty source alone
    apb_write(ADDR_IER, 8'h02);
    wait_irq(1'b1, 4, "int_o not high with transmit FIFO empty");
    fork
      begin
        apb_write(ADDR_DATA, rand_byte());
        apb_write(ADDR_DATA, rand_byte());
      end
      wait_irq(1'b0, 16, "int_o did not drop with a write pending");
    join
    // Second byte sits in the FIFO for a whole frame
    wait_irq(1'b1, 2 * FRAME_CYCLES, "int_o did not return once the FIFO drained");
    wait_tx_drain();
    apb_write(ADDR_IER, 8'h00);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b0;
    apb          = '0;
    serial_in    = 1'b1;
    seed         = 32'h3dfc_7906;
    value_errors = 0;
    other_errors = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    reset_values();
    register_access();
    transmit_frames();
    receive_and_overrun();
    loopback_path();
    interrupt_levels();
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the total serial traffic
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule
